// ==== sim.f ====
src/div_pkg.sv
src/div_operand_prep.sv
src/div_restoring_core.sv
src/div_result_fixup.sv
src/div_unit.sv
tb/tb_clk_gen.sv
tb/div_unit_tb.sv

// ==== src/div_operand_prep.sv ====
////////////////////
// purely combinational, op_valid must be a single-cycle pulse
// special cases bypass the iterative core
////////////////////
`timescale 1ns/1ps
`default_nettype none

module div_operand_prep
  import div_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  logic            op_valid,      // issue strobe, costs one credit
  input  div_op_u         op,
  input  logic [XLEN-1:0] opa,           // dividend
  input  logic [XLEN-1:0] opb,           // divisor
  output logic            start,         // normal op, core loads
  output logic            early_valid,   // special case, no iteration
  output logic [XLEN-1:0] early_result,
  output logic [XLEN-1:0] dividend_mag,
  output logic [XLEN-1:0] divisor_mag,
  output logic            neg_q,         // quotient needs negation
  output logic            neg_r          // remainder needs negation
);

  // -2^(XLEN-1)
  localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

  logic is_signed;  // DIV or REM
  logic a_neg;      // dividend sign bit
  logic b_neg;      // divisor sign bit
  logic div_zero;   // divisor is zero
  logic sgn_ovf;    // MOST_NEG / -1
  logic special;    // either of the above

  // two's complement negate
  function automatic logic [XLEN-1:0] twos(input logic [XLEN-1:0] v);
    return ~v + 1'b1;
  endfunction

  ////////////////////
  // decode
  ////////////////////

  assign is_signed = ~op.fields.is_unsigned;
  assign a_neg     = opa[XLEN-1];
  assign b_neg     = opb[XLEN-1];

  assign div_zero = (opb == '0);
  // only a signed op can overflow
  assign sgn_ovf  = is_signed && (opa == MOST_NEG) && (&opb);
  assign special  = div_zero | sgn_ovf;

  // exactly one of these per accepted op
  assign start       = op_valid & ~special;
  assign early_valid = op_valid &  special;

  // fixed answers for the special cases
  always_comb
  begin
    if (div_zero)
    begin
      // quotient all ones, remainder is the dividend
      early_result = op.fields.is_rem ? opa : '1;
    end
    else
    begin
      // overflow, quotient wraps to MOST_NEG and remainder is zero
      early_result = op.fields.is_rem ? '0 : MOST_NEG;
    end
  end

  ////////////////////
  // magnitudes and signs
  ////////////////////

  // abs(MOST_NEG) stays MOST_NEG, fine as an unsigned magnitude
  assign dividend_mag = (is_signed && a_neg) ? twos(opa) : opa;
  assign divisor_mag  = (is_signed && b_neg) ? twos(opb) : opb;

  // truncation toward zero
  assign neg_q = is_signed & (a_neg ^ b_neg);
  // remainder follows the dividend
  assign neg_r = is_signed & a_neg;

endmodule

`default_nettype wire

// ==== src/div_pkg.sv ====
////////////////////
// op code bit 1 selects remainder and bit 0 selects unsigned
// the issuer holds DIV_CREDITS credits and one op is in flight
////////////////////
`default_nettype none

package div_pkg;

  ////////////////////
  // op encoding
  ////////////////////

  // width of the op code
  localparam int DIV_OP_W = 2;

  // full-width M-extension divide ops only
  typedef enum logic [DIV_OP_W-1:0] {
    DIV  = 2'b00,  // signed quotient
    DIVU = 2'b01,  // unsigned quotient
    REM  = 2'b10,  // signed remainder
    REMU = 2'b11   // unsigned remainder
  } div_op_e;

  // same two bits seen as flags
  typedef struct packed {
    logic is_rem;       // msb, remainder wanted
    logic is_unsigned;  // lsb, no sign handling
  } div_op_fields_t;

  // one op word, read as a name or as flags
  typedef union packed {
    div_op_e        code;    // issue side and debug
    div_op_fields_t fields;  // datapath decode
  } div_op_u;

  ////////////////////
  // flow control
  ////////////////////

  // credits held by the issuer after reset
  // each result_valid pulse hands one back
  localparam int DIV_CREDITS = 1;

endpackage

`default_nettype wire

// ==== src/div_restoring_core.sv ====
////////////////////
// unsigned restoring divider, one quotient bit per clock
// start must not arrive while an op is iterating
////////////////////
`timescale 1ns/1ps
`default_nettype none

module div_restoring_core #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            rstn,
  input  logic            start,         // load pulse
  input  logic [XLEN-1:0] dividend_mag,
  input  logic [XLEN-1:0] divisor_mag,
  output logic            core_done,     // one cycle, after the last step
  output logic [XLEN-1:0] quotient,
  output logic [XLEN-1:0] remainder
);

  localparam int CNT_W = $clog2(XLEN);

  logic [XLEN-1:0]   p_q;        // partial remainder
  logic [XLEN-1:0]   a_q;        // dividend shifting out, quotient shifting in
  logic [XLEN-1:0]   b_q;        // divisor, held for the whole op
  logic [CNT_W-1:0]  cnt;        // steps still to go, zero when idle
  logic [2*XLEN-1:0] step_load;  // first step straight from the operands
  logic [2*XLEN-1:0] step_run;   // step from the registers

  // one restoring step, returns {p, a}
  function automatic logic [2*XLEN-1:0] div_step(
    input logic [XLEN-1:0] p,
    input logic [XLEN-1:0] a,
    input logic [XLEN-1:0] b
  );
    logic [XLEN:0] p_sh;
    logic [XLEN:0] diff;
    p_sh = {p, a[XLEN-1]};      // shift next dividend bit in
    diff = p_sh - {1'b0, b};
    if (diff[XLEN])
      div_step = {p_sh[XLEN-1:0], a[XLEN-2:0], 1'b0};  // borrow, restore
    else
      div_step = {diff[XLEN-1:0], a[XLEN-2:0], 1'b1};  // fits, keep difference
  endfunction

  assign step_load = div_step('0, dividend_mag, divisor_mag);
  assign step_run  = div_step(p_q, a_q, b_q);

  ////////////////////
  // sequencing
  ////////////////////

  // the load edge already does step 1, XLEN-1 steps follow
  // so core_done lands XLEN edges after start
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      cnt       <= '0;
      core_done <= 1'b0;
    end
    else if (start)
    begin
      cnt       <= CNT_W'(XLEN - 1);
      core_done <= 1'b0;
    end
    else if (cnt != '0)
    begin
      cnt       <= cnt - 1'b1;
      core_done <= (cnt == CNT_W'(1));  // final step this edge
    end
    else
    begin
      core_done <= 1'b0;
    end
  end

  ////////////////////
  // datapath
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (start)
    begin
      {p_q, a_q} <= step_load;
      b_q        <= divisor_mag;
    end
    else if (cnt != '0)
    begin
      {p_q, a_q} <= step_run;
    end
  end

  // valid while core_done is high, held until the next start
  assign quotient  = a_q;
  assign remainder = p_q;

endmodule

`default_nettype wire

// ==== src/div_result_fixup.sv ====
////////////////////
// result_valid is the credit return, one pulse per accepted op
// result holds until the next pulse
////////////////////
`timescale 1ns/1ps
`default_nettype none

module div_result_fixup
  import div_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            rstn,
  input  logic            start,         // normal op accepted
  input  div_op_u         op,
  input  logic            neg_q,
  input  logic            neg_r,
  input  logic            early_valid,   // special case accepted
  input  logic [XLEN-1:0] early_result,
  input  logic            core_done,
  input  logic [XLEN-1:0] quotient,      // magnitudes from the core
  input  logic [XLEN-1:0] remainder,
  output logic            result_valid,
  output logic [XLEN-1:0] result
);

  logic            rem_sel_q;  // captured is_rem
  logic            neg_quo_q;  // captured quotient sign
  logic            neg_rem_q;  // captured remainder sign
  logic [XLEN-1:0] sel_raw;    // magnitude picked for this op
  logic            sel_neg;
  logic [XLEN-1:0] core_res;   // signed result

  ////////////////////
  // op capture
  ////////////////////

  // op and signs only live during the issue cycle
  // early ops leave these untouched
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      rem_sel_q <= 1'b0;
      neg_quo_q <= 1'b0;
      neg_rem_q <= 1'b0;
    end
    else if (start)
    begin
      rem_sel_q <= op.fields.is_rem;
      neg_quo_q <= neg_q;
      neg_rem_q <= neg_r;
    end
  end

  // pick and sign-correct
  assign sel_raw  = rem_sel_q ? remainder : quotient;
  assign sel_neg  = rem_sel_q ? neg_rem_q : neg_quo_q;
  assign core_res = sel_neg ? (~sel_raw + 1'b1) : sel_raw;

  ////////////////////
  // writeback
  ////////////////////

  // writeback always accepts, no stall path
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      result_valid <= 1'b0;
      result       <= '0;
    end
    else
    begin
      result_valid <= early_valid | core_done;  // never both, one op in flight
      if (early_valid)
        result <= early_result;
      else if (core_done)
        result <= core_res;
    end
  end

endmodule

`default_nettype wire

// ==== src/div_unit.sv ====
////////////////////
// one op in flight, issue only while holding a credit
// special cases answer in 1 cycle, others in XLEN+1
////////////////////
`timescale 1ns/1ps
`default_nettype none

module div_unit
  import div_pkg::*;
#(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            rstn,
  input  logic            op_valid,      // spends a credit
  input  div_op_u         op,
  input  logic [XLEN-1:0] opa,
  input  logic [XLEN-1:0] opb,
  output logic            result_valid,  // returns a credit
  output logic [XLEN-1:0] result
);

  // prep to core and fixup
  logic            start;
  logic            early_valid;
  logic [XLEN-1:0] early_result;
  logic [XLEN-1:0] dividend_mag;
  logic [XLEN-1:0] divisor_mag;
  logic            neg_q;
  logic            neg_r;

  // core to fixup
  logic            core_done;
  logic [XLEN-1:0] quotient;
  logic [XLEN-1:0] remainder;

  // decode, special cases, magnitudes
  div_operand_prep #(.XLEN(XLEN)) u_prep (
    .op_valid     (op_valid),
    .op           (op),
    .opa          (opa),
    .opb          (opb),
    .start        (start),
    .early_valid  (early_valid),
    .early_result (early_result),
    .dividend_mag (dividend_mag),
    .divisor_mag  (divisor_mag),
    .neg_q        (neg_q),
    .neg_r        (neg_r)
  );

  // unsigned iteration
  div_restoring_core #(.XLEN(XLEN)) u_core (
    .clk          (clk),
    .rstn         (rstn),
    .start        (start),
    .dividend_mag (dividend_mag),
    .divisor_mag  (divisor_mag),
    .core_done    (core_done),
    .quotient     (quotient),
    .remainder    (remainder)
  );

  // sign fix and result register
  div_result_fixup #(.XLEN(XLEN)) u_fixup (
    .clk          (clk),
    .rstn         (rstn),
    .start        (start),
    .op           (op),
    .neg_q        (neg_q),
    .neg_r        (neg_r),
    .early_valid  (early_valid),
    .early_result (early_result),
    .core_done    (core_done),
    .quotient     (quotient),
    .remainder    (remainder),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

`default_nettype wire

// ==== tb/div_unit_tb.sv ====
////////////////////
// checks run as concurrent assertions on the posedge after result_valid
// one credit, issue on the falling edge, XLEN fixed at 32
////////////////////
`timescale 1ns/1ps
`default_nettype none

module div_unit_tb
  import div_pkg::*;
;

  localparam int XLEN        = 32;
  localparam int PERIOD_NS   = 40;
  localparam int N_OPS       = 120;       // sum of all test loops below
  localparam int NORMAL_LAT  = XLEN + 1;  // issue edge to the edge that sees the result
  localparam int SPECIAL_LAT = 1;
  localparam longint WATCHDOG_NS = N_OPS * (XLEN + 3) * PERIOD_NS + 4000;
  localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

  logic            clk;
  logic            rstn;
  logic            op_valid = 1'b0;
  div_op_u         op       = '0;
  logic [XLEN-1:0] opa      = '0;
  logic [XLEN-1:0] opb      = '0;
  logic            result_valid;
  logic [XLEN-1:0] result;

  // issuer side
  int              credits   = DIV_CREDITS;
  logic            credit_back = 1'b0;  // seen this cycle, usable from the next
  int              n_issued  = 0;
  logic [31:0]     lfsr      = 32'd87576;
  logic [XLEN-1:0] exp_drive = '0;  // expected value of the op being driven
  logic            spec_drive = 1'b0;
  int              tid_drive  = 0;

  // checker side, latched on the sampling edge
  logic [XLEN-1:0] exp_q      = '0;
  int              lat_q      = 0;
  int              tid_q      = 0;
  int              cyc        = 0;
  int              issue_cyc_q = 0;
  logic            inflight_q = 1'b0;
  logic            seen_q     = 1'b0;  // any op issued yet
  int              n_done     = 0;

  int err_value = 0;
  int err_lat   = 0;
  int err_proto = 0;

  tb_clk_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(2)) u_clk_gen (
    .clk  (clk),
    .rstn (rstn)
  );

  div_unit #(.XLEN(XLEN)) u_dut (
    .clk          (clk),
    .rstn         (rstn),
    .op_valid     (op_valid),
    .op           (op),
    .opa          (opa),
    .opb          (opb),
    .result_valid (result_valid),
    .result       (result)
  );

  ////////////////////
  // stimulus helpers
  ////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic string name_of(input int id);
    case (id)
      1: return "divu_rand";
      2: return "remu_rand";
      3: return "div_rand";
      4: return "rem_rand";
      5: return "div_by_zero";
      6: return "signed_ovf";
      7: return "back_to_back";
      default: return "unknown";
    endcase
  endfunction

  function automatic logic is_special(input div_op_e code, input logic [XLEN-1:0] a,
                                      input logic [XLEN-1:0] b);
    logic sgn;
    sgn = (code == DIV) || (code == REM);
    return (b == '0) || (sgn && (a == MOST_NEG) && (b == '1));
  endfunction

  // expected result straight from the M-extension rules
  function automatic logic [XLEN-1:0] ref_result(input div_op_e code,
                                                 input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
    logic signed [XLEN-1:0] sa;
    logic signed [XLEN-1:0] sb;
    sa = a;
    sb = b;
    case (code)
      DIVU: return (b == '0) ? '1 : a / b;
      REMU: return (b == '0) ? a : a % b;
      DIV:
      begin
        if (b == '0)                        return '1;
        else if (a == MOST_NEG && b == '1)  return MOST_NEG;
        else                                return sa / sb;  // truncates toward zero
      end
      default:
      begin
        if (b == '0)                        return a;
        else if (a == MOST_NEG && b == '1)  return '0;
        else                                return sa % sb;  // sign of dividend
      end
    endcase
  endfunction

  // one falling edge, a returned credit counts from the next one
  task automatic next_cycle();
    @(negedge clk);
    if (credit_back)
      credits++;
    credit_back = result_valid;
  endtask

  task automatic issue_op(input div_op_e code, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b, input int tid);
    while (credits == 0)
      next_cycle();
    op.code    = code;
    opa        = a;
    opb        = b;
    exp_drive  = ref_result(code, a, b);
    spec_drive = is_special(code, a, b);
    tid_drive  = tid;
    op_valid   = 1'b1;
    credits--;
    n_issued++;
    next_cycle();
    op_valid = 1'b0;
  endtask

  // random divisor of random width, never zero
  function automatic logic [XLEN-1:0] rand_divisor();
    logic [XLEN-1:0] b;
    b = take_bits(1 + int'(take_bits(5)));
    if (b == '0)
      b = 1;
    return b;
  endfunction

  ////////////////////
  // checker bookkeeping
  ////////////////////

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
    if (result_valid)
      n_done <= n_done + 1;
    if (op_valid)
    begin
      exp_q       <= exp_drive;
      lat_q       <= spec_drive ? SPECIAL_LAT : NORMAL_LAT;
      tid_q       <= tid_drive;
      issue_cyc_q <= cyc;
      inflight_q  <= 1'b1;
      seen_q      <= 1'b1;
    end
    else if (result_valid)
      inflight_q <= 1'b0;
  end

  ////////////////////
  // assertions
  ////////////////////

  a_value: assert property (@(posedge clk) disable iff (!rstn)
    result_valid |-> (result == exp_q))
  else
  begin
    err_value++;
    $display("error %s expected %h actual %h", name_of($sampled(tid_q)),
             $sampled(exp_q), $sampled(result));
  end

  // edges from the issue edge to the one that samples result_valid
  a_latency: assert property (@(posedge clk) disable iff (!rstn)
    result_valid |-> (cyc - issue_cyc_q == lat_q))
  else
  begin
    err_lat++;
    $display("error %s latency expected %0d actual %0d", name_of($sampled(tid_q)),
             $sampled(lat_q), $sampled(cyc) - $sampled(issue_cyc_q));
  end

  a_owner: assert property (@(posedge clk) disable iff (!rstn)
    result_valid |-> inflight_q)
  else
  begin
    err_proto++;
    $display("result_valid arrived with no operation outstanding");
  end

  a_pulse: assert property (@(posedge clk) disable iff (!rstn)
    result_valid |=> !result_valid)
  else
  begin
    err_proto++;
    $display("result_valid stayed high for more than one cycle");
  end

  a_idle: assert property (@(posedge clk) disable iff (!rstn)
    !seen_q |-> (!result_valid && result == '0))
  else
  begin
    err_proto++;
    $display("result port not idle and zero before the first issue");
  end

  ////////////////////
  // tests
  ////////////////////

  initial
  begin
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [1:0]      sel;
    div_op_e         code;
    @(posedge rstn);
    repeat (5) next_cycle();  // idle, a_idle watches

    for (int i = 0; i < 40; i++)  // unsigned
      issue_op((i < 20) ? DIVU : REMU, take_bits(XLEN), rand_divisor(), (i < 20) ? 1 : 2);

    for (int i = 0; i < 40; i++)  // signed, all four sign pairs
    begin
      a         = take_bits(XLEN);
      a[XLEN-1] = i[0];
      b         = rand_divisor();
      if (i[1])
        b = ~b + 1'b1;
      issue_op((i < 20) ? DIV : REM, a, b, (i < 20) ? 3 : 4);
    end

    for (int i = 0; i < 3; i++)  // zero divisor
    begin
      a = (i == 0) ? MOST_NEG : take_bits(XLEN);
      issue_op(DIV, a, '0, 5);
      issue_op(DIVU, a, '0, 5);
      issue_op(REM, a, '0, 5);
      issue_op(REMU, a, '0, 5);
    end

    // overflow, unsigned ones take the normal path
    issue_op(DIV, MOST_NEG, '1, 6);
    issue_op(REM, MOST_NEG, '1, 6);
    issue_op(DIVU, MOST_NEG, '1, 6);
    issue_op(REMU, MOST_NEG, '1, 6);

    for (int i = 0; i < 24; i++)  // mixed special and normal
    begin
      code = div_op_e'(2'(take_bits(2)));
      sel  = 2'(take_bits(2));
      a    = take_bits(XLEN);
      b    = (sel == 2'd0) ? '0 : rand_divisor();
      if (sel == 2'd1)
      begin
        a = MOST_NEG;
        b = '1;
      end
      else if (sel == 2'd2)
        b = ~b + 1'b1;
      issue_op(code, a, b, 7);
    end

    while (credits < DIV_CREDITS)
      next_cycle();
    repeat (2) next_cycle();  // let the last check fire

    if (n_done != n_issued)
    begin
      err_proto++;
      $display("%0d results for %0d issued operations", n_done, n_issued);
    end
    $display("errors: value %0d, latency %0d, protocol %0d", err_value, err_lat, err_proto);
    if (err_value + err_lat + err_proto == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

  // watchdog
  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d of %0d operations", n_done, N_OPS);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/tb_clk_gen.sv ====
////////////////////
// free-running clock, rstn released on a falling edge
////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic rstn
);

  initial clk = 1'b0;
  always #(PERIOD_NS / 2) clk = ~clk;

  initial
  begin
    rstn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);  // away from the sampling edge
    rstn = 1'b1;
  end

endmodule

`default_nettype wire
